// File: hdd_pkg.sv
package hdd_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int data_w       = 8;
    localparam int sec_addr_w   = 9;
    localparam int sector_bytes = 512;  // One ProDOS block
    localparam int reg_idx_w    = 4;

    // ------------------------------
    // Register offsets from C0F0
    // ------------------------------
    localparam logic [reg_idx_w-1:0] reg_execute   = 4'h0;  // Read runs the command
    localparam logic [reg_idx_w-1:0] reg_status    = 4'h1;
    localparam logic [reg_idx_w-1:0] reg_command   = 4'h2;
    localparam logic [reg_idx_w-1:0] reg_unit      = 4'h3;
    localparam logic [reg_idx_w-1:0] reg_mem_l     = 4'h4;
    localparam logic [reg_idx_w-1:0] reg_mem_h     = 4'h5;
    localparam logic [reg_idx_w-1:0] reg_block_l   = 4'h6;
    localparam logic [reg_idx_w-1:0] reg_block_h   = 4'h7;
    localparam logic [reg_idx_w-1:0] reg_next_byte = 4'h8;  // Sector byte stream

    // ProDOS command codes
    localparam logic [data_w-1:0] cmd_status = 8'h00;
    localparam logic [data_w-1:0] cmd_read   = 8'h01;
    localparam logic [data_w-1:0] cmd_write  = 8'h02;

    // Status codes as seen at C0F0 and C0F1
    localparam logic [data_w-1:0] sts_ok      = 8'h00;
    localparam logic [data_w-1:0] sts_error   = 8'h01;
    localparam logic [data_w-1:0] sts_busy    = 8'h80;  // Transfer in progress
    localparam logic [data_w-1:0] sts_protect = 8'h2B;

    // Bus value when nothing is being read
    localparam logic [data_w-1:0] idle_data = 8'hFF;

    // Command block as loaded by the driver
    typedef struct packed {
        logic [data_w-1:0]   command;
        logic [data_w-1:0]   unit;
        logic [2*data_w-1:0] mem;    // Host memory buffer address
        logic [2*data_w-1:0] block;  // Block number on the image
    } hdd_cfg_t;

endpackage

// File: hdd_bus_if.sv
interface hdd_bus_if;

    // Decoded register access, valid for the access clock only
    logic                          rd_stb;
    logic                          wr_stb;
    logic [hdd_pkg::reg_idx_w-1:0] index;
    logic [hdd_pkg::data_w-1:0]    wdata;

    // Address decoder side
    modport decoder (
        output rd_stb,
        output wr_stb,
        output index,
        output wdata
    );

    // Blocks steered by register accesses
    modport target (
        input rd_stb,
        input wr_stb,
        input index,
        input wdata
    );

endinterface

// File: hdd_regs.sv
module hdd_regs (
    input  logic                          CLK_14M,
    input  logic                          RESET,
    input  logic                          phi0,
    input  logic                          device_select,
    input  logic                          rd,
    input  logic [hdd_pkg::reg_idx_w-1:0] addr,
    input  logic [hdd_pkg::data_w-1:0]    d_in,
    hdd_bus_if.decoder                    bus,
    output hdd_pkg::hdd_cfg_t             cfg
);

    logic access;

    // ------------------------------
    // Access decode
    // ------------------------------
    assign access = phi0 & device_select;  // One clock per CPU cycle

    assign bus.rd_stb = access & rd;
    assign bus.wr_stb = access & ~rd;
    assign bus.index  = addr;
    assign bus.wdata  = d_in;

    // ------------------------------
    // Command block registers
    // ------------------------------
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            cfg <= '0;
        end else if (bus.wr_stb) begin
            case (bus.index)
                hdd_pkg::reg_command: cfg.command     <= bus.wdata;
                hdd_pkg::reg_unit:    cfg.unit        <= bus.wdata;
                hdd_pkg::reg_mem_l:   cfg.mem[7:0]    <= bus.wdata;
                hdd_pkg::reg_mem_h:   cfg.mem[15:8]   <= bus.wdata;
                hdd_pkg::reg_block_l: cfg.block[7:0]  <= bus.wdata;
                hdd_pkg::reg_block_h: cfg.block[15:8] <= bus.wdata;
                // Execute and status are read-only, next byte goes to the buffer
                default: ;
            endcase
        end
    end

    // Buffer read latency is hidden by three idle clocks after each access
    a_access_gap: assert property (
        @(posedge CLK_14M) disable iff (RESET)
        access |=> !access ##1 !access ##1 !access
    );

endmodule

// File: hdd_controller.sv
module hdd_controller (
    input  logic                       CLK_14M,
    input  logic                       RESET,
    hdd_bus_if.target                  bus,
    input  hdd_pkg::hdd_cfg_t          cfg,
    input  logic [hdd_pkg::data_w-1:0] next_byte,
    input  logic                       last_byte,
    input  logic                       hdd_mounted,
    input  logic                       hdd_protect,
    output logic [hdd_pkg::data_w-1:0] d_out,
    output logic                       hdd_read,
    output logic                       hdd_write
);

    logic [hdd_pkg::data_w-1:0] status;
    logic                       cmd_wr;
    logic                       xfer_cmd;  // Command write starts a transfer

    assign cmd_wr   = bus.wr_stb && (bus.index == hdd_pkg::reg_command);
    assign xfer_cmd = (bus.wdata == hdd_pkg::cmd_read) || (bus.wdata == hdd_pkg::cmd_write);

    // ------------------------------
    // Status, strobes and read data
    // ------------------------------
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            status    <= hdd_pkg::sts_ok;
            d_out     <= hdd_pkg::idle_data;
            hdd_read  <= 1'b0;
            hdd_write <= 1'b0;
        end else begin
            d_out     <= hdd_pkg::idle_data;  // Bus idles high between reads
            hdd_read  <= 1'b0;
            hdd_write <= 1'b0;

            if (last_byte)
                status <= hdd_pkg::sts_ok;    // Whole sector streamed out

            if (cmd_wr)
                status <= xfer_cmd ? hdd_pkg::sts_busy : hdd_pkg::sts_ok;

            if (bus.rd_stb) begin
                case (bus.index)
                    hdd_pkg::reg_execute: begin
                        case (cfg.command)
                            hdd_pkg::cmd_status: begin
                                d_out  <= status;  // Old value, then refresh
                                status <= hdd_mounted ? hdd_pkg::sts_ok
                                                      : hdd_pkg::sts_error;
                            end
                            hdd_pkg::cmd_read: begin
                                if (hdd_mounted) begin
                                    d_out    <= status;
                                    hdd_read <= 1'b1;  // Host fills the buffer
                                end else begin
                                    d_out  <= hdd_pkg::sts_error;
                                    status <= hdd_pkg::sts_error;
                                end
                            end
                            hdd_pkg::cmd_write: begin
                                if (hdd_protect) begin
                                    d_out  <= hdd_pkg::sts_protect;
                                    status <= hdd_pkg::sts_error;
                                end else if (hdd_mounted) begin
                                    d_out     <= status;
                                    hdd_write <= 1'b1;
                                end else begin
                                    d_out  <= hdd_pkg::sts_error;
                                    status <= hdd_pkg::sts_error;
                                end
                            end
                            default: d_out <= status;  // Unknown commands do nothing
                        endcase
                    end
                    hdd_pkg::reg_status:    d_out <= status;
                    hdd_pkg::reg_command:   d_out <= cfg.command;
                    hdd_pkg::reg_unit:      d_out <= cfg.unit;
                    hdd_pkg::reg_mem_l:     d_out <= cfg.mem[7:0];
                    hdd_pkg::reg_mem_h:     d_out <= cfg.mem[15:8];
                    hdd_pkg::reg_block_l:   d_out <= cfg.block[7:0];
                    hdd_pkg::reg_block_h:   d_out <= cfg.block[15:8];
                    hdd_pkg::reg_next_byte: d_out <= next_byte;  // Pointer advances elsewhere
                    default:                d_out <= hdd_pkg::idle_data;
                endcase
            end
        end
    end

    // ------------------------------
    // Host strobe checks
    // ------------------------------
    a_strobe_excl: assert property (
        @(posedge CLK_14M) disable iff (RESET)
        !(hdd_read && hdd_write)
    );

    a_read_pulse: assert property (
        @(posedge CLK_14M) disable iff (RESET)
        hdd_read |=> !hdd_read
    );

    a_write_pulse: assert property (
        @(posedge CLK_14M) disable iff (RESET)
        hdd_write |=> !hdd_write
    );

endmodule

// File: hdd_byte_stream.sv
module hdd_byte_stream (
    input  logic                           CLK_14M,
    input  logic                           RESET,
    hdd_bus_if.target                      bus,
    input  logic [hdd_pkg::data_w-1:0]     ram_q,
    output logic [hdd_pkg::sec_addr_w-1:0] ram_addr_b,
    output logic                           ram_we_b,
    output logic [hdd_pkg::data_w-1:0]     ram_d_b,
    output logic [hdd_pkg::data_w-1:0]     next_byte,
    output logic                           last_byte
);

    logic [hdd_pkg::sec_addr_w-1:0] ptr;
    logic                           restart;   // READ or WRITE written to C0F2
    logic                           byte_rd;
    logic                           byte_wr;

    assign restart = bus.wr_stb && (bus.index == hdd_pkg::reg_command) &&
                     ((bus.wdata == hdd_pkg::cmd_read) || (bus.wdata == hdd_pkg::cmd_write));
    assign byte_rd = bus.rd_stb && (bus.index == hdd_pkg::reg_next_byte);
    assign byte_wr = bus.wr_stb && (bus.index == hdd_pkg::reg_next_byte);

    assign ram_addr_b = ptr;  // Pointer holds still while a store is pending

    // Pointer moves after a read, or after a store has landed
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            ptr       <= '0;
            ram_we_b  <= 1'b0;
            last_byte <= 1'b0;
        end else begin
            ram_we_b  <= byte_wr;
            last_byte <= byte_rd && (ptr == hdd_pkg::sec_addr_w'(hdd_pkg::sector_bytes - 1));
            if (restart)
                ptr <= '0;
            else if (byte_rd || ram_we_b)
                ptr <= ptr + 1'b1;
        end
    end

    // ------------------------------
    // Data paths
    // ------------------------------
    always_ff @(posedge CLK_14M) begin
        if (byte_wr)
            ram_d_b <= bus.wdata;
        next_byte <= ram_q;  // Second stage after the buffer read
    end

endmodule

// File: hdd_sector_ram.sv
module hdd_sector_ram (
    input  logic                           CLK_14M,
    input  logic [hdd_pkg::sec_addr_w-1:0] addr_a,
    input  logic                           we_a,
    input  logic [hdd_pkg::data_w-1:0]     d_a,
    output logic [hdd_pkg::data_w-1:0]     q_a,
    input  logic [hdd_pkg::sec_addr_w-1:0] addr_b,
    input  logic                           we_b,
    input  logic [hdd_pkg::data_w-1:0]     d_b,
    output logic [hdd_pkg::data_w-1:0]     q_b
);

    logic [hdd_pkg::data_w-1:0] mem [hdd_pkg::sector_bytes];
    logic [hdd_pkg::data_w-1:0] rd_a;

    // Port A, host DMA side
    always @(posedge CLK_14M) begin
        if (we_a)
            mem[addr_a] <= d_a;
        rd_a <= mem[addr_a];
    end

    // Port B, CPU byte stream side
    always @(posedge CLK_14M) begin
        if (we_b)
            mem[addr_b] <= d_b;
        q_b <= mem[addr_b];
    end

    always_ff @(posedge CLK_14M) begin
        q_a <= rd_a;  // Readback two clocks after the address
    end

endmodule

// File: hdd_card.sv
module hdd_card (
    input  logic                           CLK_14M,
    input  logic                           RESET,
    input  logic                           phi0,
    input  logic                           device_select,
    input  logic                           rd,
    input  logic [hdd_pkg::reg_idx_w-1:0]  addr,
    input  logic [hdd_pkg::data_w-1:0]     d_in,
    output logic [hdd_pkg::data_w-1:0]     d_out,
    output logic [2*hdd_pkg::data_w-1:0]   sector,
    output logic                           hdd_read,
    output logic                           hdd_write,
    input  logic                           hdd_mounted,
    input  logic                           hdd_protect,
    input  logic [hdd_pkg::sec_addr_w-1:0] ram_addr,
    input  logic [hdd_pkg::data_w-1:0]     ram_di,
    input  logic                           ram_we,
    output logic [hdd_pkg::data_w-1:0]     ram_do
);

    hdd_pkg::hdd_cfg_t              cfg;
    logic [hdd_pkg::data_w-1:0]     next_byte;
    logic                           last_byte;

    // ------------------------------
    // Sector buffer port B
    // ------------------------------
    logic [hdd_pkg::sec_addr_w-1:0] buf_addr;
    logic                           buf_we;
    logic [hdd_pkg::data_w-1:0]     buf_d;
    logic [hdd_pkg::data_w-1:0]     buf_q;

    hdd_bus_if bus ();

    assign sector = cfg.block;  // Block number for the host

    hdd_regs u_regs (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .phi0          (phi0),
        .device_select (device_select),
        .rd            (rd),
        .addr          (addr),
        .d_in          (d_in),
        .bus           (bus.decoder),
        .cfg           (cfg)
    );

    hdd_controller u_controller (
        .CLK_14M     (CLK_14M),
        .RESET       (RESET),
        .bus         (bus.target),
        .cfg         (cfg),
        .next_byte   (next_byte),
        .last_byte   (last_byte),
        .hdd_mounted (hdd_mounted),
        .hdd_protect (hdd_protect),
        .d_out       (d_out),
        .hdd_read    (hdd_read),
        .hdd_write   (hdd_write)
    );

    hdd_byte_stream u_byte_stream (
        .CLK_14M    (CLK_14M),
        .RESET      (RESET),
        .bus        (bus.target),
        .ram_q      (buf_q),
        .ram_addr_b (buf_addr),
        .ram_we_b   (buf_we),
        .ram_d_b    (buf_d),
        .next_byte  (next_byte),
        .last_byte  (last_byte)
    );

    hdd_sector_ram u_sector_ram (
        .CLK_14M (CLK_14M),
        .addr_a  (ram_addr),
        .we_a    (ram_we),
        .d_a     (ram_di),
        .q_a     (ram_do),
        .addr_b  (buf_addr),
        .we_b    (buf_we),
        .d_b     (buf_d),
        .q_b     (buf_q)
    );

endmodule

// File: hdd_checker.sv
module hdd_checker (
    input  logic                         CLK_14M,
    input  logic                         RESET,
    input  logic [hdd_pkg::data_w-1:0]   d_out,
    input  logic [hdd_pkg::data_w-1:0]   ram_do,
    input  logic [2*hdd_pkg::data_w-1:0] sector,
    input  logic                         hdd_read,
    input  logic                         hdd_write
);

    // Pending checks, source 0 is d_out, 1 is ram_do, 2 is sector
    string                        name_q[$];
    logic [2*hdd_pkg::data_w-1:0] exp_q[$];
    int                           src_q[$];
    int                           due_q[$];   // Falling edges left before sampling

    int checks;
    int errors;
    int read_pulses;
    int write_pulses;

    initial begin
        checks       = 0;
        errors       = 0;
        read_pulses  = 0;
        write_pulses = 0;
    end

    function automatic int pending_checks();
        return name_q.size();
    endfunction

    // Queue a check, called on the clock the access or address is driven
    task automatic expect_value(input string name, input logic [15:0] exp, input int src);
        name_q.push_back(name);
        exp_q.push_back(exp);
        src_q.push_back(src);
        due_q.push_back(src == 1 ? 3 : (src == 0 ? 2 : 1));
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // ------------------------------
    // Sampling on the falling edge
    // ------------------------------
    always @(negedge CLK_14M) begin
        logic [15:0] act;
        if (!RESET) begin
            if (hdd_read)
                read_pulses++;    // Strobes last one clock each
            if (hdd_write)
                write_pulses++;
        end
        for (int i = 0; i < due_q.size(); i++)
            due_q[i] = due_q[i] - 1;
        while (due_q.size() > 0 && due_q[0] <= 0) begin
            case (src_q[0])
                0:       act = {8'h00, d_out};
                1:       act = {8'h00, ram_do};  // DMA readback
                default: act = sector;
            endcase
            checks++;
            if (act !== exp_q[0]) begin
                errors++;
                if (src_q[0] == 2)
                    $display("Mismatch %s: expected %h actual %h", name_q[0], exp_q[0], act);
                else
                    $display("Mismatch %s: expected %h actual %h", name_q[0],
                             exp_q[0][7:0], act[7:0]);
            end
            void'(name_q.pop_front());
            void'(exp_q.pop_front());
            void'(src_q.pop_front());
            void'(due_q.pop_front());
        end
    end

endmodule

// File: tb_hdd.sv
module tb_hdd;

    logic                           CLK_14M;
    logic                           RESET;
    logic                           phi0;
    logic                           device_select;
    logic                           rd;
    logic [hdd_pkg::reg_idx_w-1:0]  addr;
    logic [hdd_pkg::data_w-1:0]     d_in;
    logic [hdd_pkg::data_w-1:0]     d_out;
    logic [2*hdd_pkg::data_w-1:0]   sector;
    logic                           hdd_read;
    logic                           hdd_write;
    logic                           hdd_mounted;
    logic                           hdd_protect;
    logic [hdd_pkg::sec_addr_w-1:0] ram_addr;
    logic [hdd_pkg::data_w-1:0]     ram_di;
    logic                           ram_we;
    logic [hdd_pkg::data_w-1:0]     ram_do;

    // Reference model state
    logic [31:0]                lcg_state;
    logic [hdd_pkg::data_w-1:0] sector_model [hdd_pkg::sector_bytes];
    logic [hdd_pkg::data_w-1:0] regs_model [8];
    logic [hdd_pkg::data_w-1:0] status_model;
    logic [hdd_pkg::data_w-1:0] cmd_model;
    int                         tests;
    int                         err_mark;

    always #5 CLK_14M = ~CLK_14M;

    hdd_card u_dut (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .phi0          (phi0),
        .device_select (device_select),
        .rd            (rd),
        .addr          (addr),
        .d_in          (d_in),
        .d_out         (d_out),
        .sector        (sector),
        .hdd_read      (hdd_read),
        .hdd_write     (hdd_write),
        .hdd_mounted   (hdd_mounted),
        .hdd_protect   (hdd_protect),
        .ram_addr      (ram_addr),
        .ram_di        (ram_di),
        .ram_we        (ram_we),
        .ram_do        (ram_do)
    );

    hdd_checker u_chk (
        .CLK_14M   (CLK_14M),
        .RESET     (RESET),
        .d_out     (d_out),
        .ram_do    (ram_do),
        .sector    (sector),
        .hdd_read  (hdd_read),
        .hdd_write (hdd_write)
    );

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // Ends 1 unit after a rising edge, where inputs change
    task automatic tick(input int n);
        repeat (n) @(posedge CLK_14M);
        #1;
    endtask

    task automatic start_access(input logic is_rd, input logic [3:0] idx, input logic [7:0] data);
        phi0          = 1'b1;
        device_select = 1'b1;
        rd            = is_rd;
        addr          = idx;
        d_in          = data;
        tick(1);
        phi0          = 1'b0;
        device_select = 1'b0;
    endtask

    task automatic cpu_write(input logic [3:0] idx, input logic [7:0] data);
        if (idx == hdd_pkg::reg_command) begin
            cmd_model    = data;
            status_model = (data == hdd_pkg::cmd_read || data == hdd_pkg::cmd_write) ?
                           hdd_pkg::sts_busy : hdd_pkg::sts_ok;
        end
        start_access(1'b0, idx, data);
        tick(3);
    endtask

    task automatic cpu_read(input logic [3:0] idx, input logic [7:0] exp, input string name);
        u_chk.expect_value(name, {8'h00, exp}, 0);
        start_access(1'b1, idx, 8'h00);
        tick(3);
    endtask

    // ------------------------------
    // C0F0 read against the model
    // ------------------------------
    task automatic run_execute(input string name);
        logic [7:0] ret;
        int         want_rd;
        int         want_wr;
        int         rd0;
        int         wr0;
        int         n;
        ret     = status_model;
        want_rd = 0;
        want_wr = 0;
        case (cmd_model)
            hdd_pkg::cmd_status: begin
                status_model = hdd_mounted ? hdd_pkg::sts_ok : hdd_pkg::sts_error;
            end
            hdd_pkg::cmd_read: begin
                if (hdd_mounted) begin
                    want_rd = 1;
                end else begin
                    ret          = hdd_pkg::sts_error;
                    status_model = hdd_pkg::sts_error;
                end
            end
            hdd_pkg::cmd_write: begin
                if (hdd_protect) begin
                    ret          = hdd_pkg::sts_protect;
                    status_model = hdd_pkg::sts_error;
                end else if (hdd_mounted) begin
                    want_wr = 1;
                end else begin
                    ret          = hdd_pkg::sts_error;
                    status_model = hdd_pkg::sts_error;
                end
            end
            default: ;
        endcase
        rd0 = u_chk.read_pulses;
        wr0 = u_chk.write_pulses;
        u_chk.expect_value(name, {8'h00, ret}, 0);
        start_access(1'b1, hdd_pkg::reg_execute, 8'h00);
        if (want_rd || want_wr) begin
            for (n = 0; n < 8 && u_chk.read_pulses == rd0 && u_chk.write_pulses == wr0; n++)
                tick(1);
            if (n == 8)
                u_chk.note_failure({name, ": timeout waiting for the host strobe"});
        end
        tick(3);
        if (u_chk.read_pulses - rd0 != want_rd || u_chk.write_pulses - wr0 != want_wr)
            u_chk.note_failure($sformatf("Mismatch %s: expected rd %0d wr %0d actual rd %0d wr %0d",
                               name, want_rd, want_wr, u_chk.read_pulses - rd0,
                               u_chk.write_pulses - wr0));
    endtask

    task automatic end_test(input string name);
        int n;
        int errs;
        for (n = 0; n < 10 && u_chk.pending_checks() > 0; n++)
            tick(1);
        if (u_chk.pending_checks() > 0)
            u_chk.note_failure({name, ": checks still pending after timeout"});
        errs = u_chk.errors - err_mark;
        tests++;
        if (errs == 0)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, errs);
        err_mark = u_chk.errors;
    endtask

    initial begin
        int         i;
        logic [7:0] val;
        CLK_14M       = 1'b0;
        RESET         = 1'b1;
        phi0          = 1'b0;
        device_select = 1'b0;
        rd            = 1'b0;
        addr          = '0;
        d_in          = '0;
        hdd_mounted   = 1'b0;
        hdd_protect   = 1'b0;
        ram_addr      = '0;
        ram_di        = '0;
        ram_we        = 1'b0;
        lcg_state     = 32'he185;
        status_model  = hdd_pkg::sts_ok;
        cmd_model     = hdd_pkg::cmd_status;
        tests         = 0;
        err_mark      = 0;
        repeat (5) @(posedge CLK_14M);
        #1;
        RESET = 1'b0;
        tick(1);

        // Register readback and sector output
        for (i = 3; i <= 7; i++) begin
            val           = rand_byte();
            regs_model[i] = val;
            cpu_write(hdd_pkg::reg_idx_w'(i), val);
        end
        for (i = 3; i <= 7; i++)
            cpu_read(hdd_pkg::reg_idx_w'(i), regs_model[i], $sformatf("regs[%0d]", i));
        u_chk.expect_value("regs_sector", {regs_model[7], regs_model[6]}, 2);
        tick(1);
        end_test("regs");

        cpu_write(hdd_pkg::reg_command, hdd_pkg::cmd_status);
        for (i = 0; i < 4; i++) begin
            hdd_mounted = i[0] ? ~hdd_mounted : (rand_byte() >= 8'h80);  // Both paths seen
            run_execute("status_exec");
            cpu_read(hdd_pkg::reg_status, status_model, "status_reg");
        end
        end_test("status_cmd");

        // ------------------------------
        // READ transfer
        // ------------------------------
        hdd_mounted = 1'b1;
        hdd_protect = 1'b0;
        ram_we      = 1'b1;
        for (i = 0; i < hdd_pkg::sector_bytes; i++) begin
            val             = rand_byte();
            sector_model[i] = val;
            ram_addr        = hdd_pkg::sec_addr_w'(i);
            ram_di          = val;
            tick(1);
        end
        ram_we = 1'b0;
        cpu_write(hdd_pkg::reg_command, hdd_pkg::cmd_read);
        cpu_read(hdd_pkg::reg_status, status_model, "read_busy");
        run_execute("read_exec");
        for (i = 0; i < hdd_pkg::sector_bytes; i++)
            cpu_read(hdd_pkg::reg_next_byte, sector_model[i], $sformatf("read_byte[%0d]", i));
        status_model = hdd_pkg::sts_ok;  // Byte 511 ends the transfer
        cpu_read(hdd_pkg::reg_status, status_model, "read_done");
        end_test("read_xfer");

        cpu_write(hdd_pkg::reg_command, hdd_pkg::cmd_write);
        run_execute("write_exec");
        for (i = 0; i < hdd_pkg::sector_bytes; i++) begin
            val             = rand_byte();
            sector_model[i] = val;
            cpu_write(hdd_pkg::reg_next_byte, val);
        end
        for (i = 0; i < hdd_pkg::sector_bytes; i++) begin
            ram_addr = hdd_pkg::sec_addr_w'(i);
            u_chk.expect_value($sformatf("write_dma[%0d]", i), {8'h00, sector_model[i]}, 1);
            tick(1);
        end
        tick(3);
        end_test("write_xfer");

        // ------------------------------
        // Error paths
        // ------------------------------
        hdd_protect = 1'b1;
        hdd_mounted = rand_byte() >= 8'h80;
        cpu_write(hdd_pkg::reg_command, hdd_pkg::cmd_write);
        run_execute("protect_exec");
        cpu_read(hdd_pkg::reg_status, status_model, "protect_status");
        hdd_protect = 1'b0;
        hdd_mounted = 1'b0;
        cpu_write(hdd_pkg::reg_command, hdd_pkg::cmd_read);
        run_execute("unmounted_read");
        cpu_read(hdd_pkg::reg_status, status_model, "unmounted_read_status");
        cpu_write(hdd_pkg::reg_command, hdd_pkg::cmd_write);
        run_execute("unmounted_write");
        cpu_read(hdd_pkg::reg_status, status_model, "unmounted_write_status");
        end_test("errors");

        $display("Tests %0d, checks %0d, errors %0d", tests, u_chk.checks, u_chk.errors);
        if (u_chk.errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: sources.f
hdd_pkg.sv
hdd_bus_if.sv
hdd_regs.sv
hdd_controller.sv
hdd_byte_stream.sv
hdd_sector_ram.sv
hdd_card.sv
hdd_checker.sv
tb_hdd.sv
